//--- design/seg_display_pkg.sv
package seg_display_pkg;

    //////////////////////////////////////////////////////////////////////
    // Data widths
    //////////////////////////////////////////////////////////////////////

    localparam int value_width  = 32;
    localparam int nibble_width = 4;
    // Segment bus is g down to a, active high
    localparam int seg_width    = 7;
    localparam int an_width     = 8;

    //////////////////////////////////////////////////////////////////////
    // Digit enable patterns
    //////////////////////////////////////////////////////////////////////

    // High nibble of every byte on the odd positions
    localparam logic [an_width-1:0] an_phase_hi = 8'b1010_1010;
    localparam logic [an_width-1:0] an_phase_lo = 8'b0101_0101;
    // Nothing lit before the first commit
    localparam logic [an_width-1:0] an_blank    = 8'b0000_0000;

    //////////////////////////////////////////////////////////////////////
    // Flow control and refresh
    //////////////////////////////////////////////////////////////////////

    // Queue depth, also the writer's starting credit
    localparam int credit_count = 2;

    localparam int sys_clk_hz         = 50_000_000;
    localparam int refresh_hz         = 780;
    localparam int default_div_factor = sys_clk_hz / (2 * refresh_hz);

    // Update controller states
    localparam logic st_blank = 1'b0;
    localparam logic st_show  = 1'b1;

endpackage

//--- design/seg7.sv
module seg7 (
    input  logic [seg_display_pkg::nibble_width-1:0] din,
    output logic [seg_display_pkg::seg_width-1:0]    dout
);

    // Bit 6 is segment g, bit 0 is segment a
    always_comb begin
        case (din)
            4'h0:    dout = 7'b011_1111;
            4'h1:    dout = 7'b000_0110;
            4'h2:    dout = 7'b101_1011;
            4'h3:    dout = 7'b100_1111;
            4'h4:    dout = 7'b110_0110;
            4'h5:    dout = 7'b110_1101;
            4'h6:    dout = 7'b111_1101;
            4'h7:    dout = 7'b000_0111;
            4'h8:    dout = 7'b111_1111;
            4'h9:    dout = 7'b110_1111;
            // Letters, lower case b and d to keep them apart from 8 and 0
            4'ha:    dout = 7'b111_0111;
            4'hb:    dout = 7'b111_1100;
            4'hc:    dout = 7'b011_1001;
            4'hd:    dout = 7'b101_1110;
            4'he:    dout = 7'b111_1001;
            4'hf:    dout = 7'b111_0001;
            default: dout = 7'b000_0000;
        endcase
    end

endmodule

//--- design/scan_timer.sv
module scan_timer #(
    parameter int div_factor = seg_display_pkg::default_div_factor
) (
    input  logic clk,
    input  logic rst,
    output logic phase,
    output logic frame_start
);

    localparam int cnt_width = (div_factor > 1) ? $clog2(div_factor) : 1;
    localparam logic [cnt_width-1:0] cnt_last = cnt_width'(div_factor - 1);

    logic [cnt_width-1:0] cnt;
    logic                 wrap;

    assign wrap = (cnt == cnt_last);

    //////////////////////////////////////////////////////////////////////
    // Divide counter and phase toggle
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt   <= '0;
            phase <= 1'b0;
        end else if (wrap) begin
            cnt   <= '0;
            phase <= ~phase;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Last cycle of phase 1 ends the frame
    assign frame_start = wrap & phase;

    // Counter stays inside its divide range
    cnt_in_range: assert property (
        @(posedge clk) disable iff (rst)
        cnt <= cnt_last
    ) else $error("scan_timer: counter beyond div_factor - 1");

endmodule

//--- design/value_fifo.sv
module value_fifo (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    push,
    input  logic [seg_display_pkg::value_width-1:0] push_data,
    input  logic                                    pop,
    output logic [seg_display_pkg::value_width-1:0] head_data,
    output logic                                    fifo_empty,
    output logic                                    credit_return
);

    import seg_display_pkg::*;

    localparam int ptr_width = (credit_count > 1) ? $clog2(credit_count) : 1;
    localparam int occ_width = $clog2(credit_count + 1);
    localparam logic [ptr_width-1:0] ptr_last = ptr_width'(credit_count - 1);
    localparam logic [occ_width-1:0] occ_full = occ_width'(credit_count);

    logic [value_width-1:0] mem [credit_count];
    logic [ptr_width-1:0]   wr_ptr;
    logic [ptr_width-1:0]   rd_ptr;
    logic [occ_width-1:0]   occ;
    logic                   fifo_full;

    function automatic logic [ptr_width-1:0] ptr_next(input logic [ptr_width-1:0] p);
        return (p == ptr_last) ? '0 : p + 1'b1;
    endfunction

    assign fifo_empty = (occ == '0);
    assign fifo_full  = (occ == occ_full);
    assign head_data  = mem[rd_ptr];

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers, occupancy and the registered credit pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            occ           <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, pop})
                2'b10:   occ <= occ + 1'b1;
                2'b01:   occ <= occ - 1'b1;
                default: occ <= occ;
            endcase
            credit_return <= pop;
        end
    end

    // Writer spent a credit it did not hold
    no_push_when_full: assert property (
        @(posedge clk) disable iff (rst)
        push |-> !fifo_full
    ) else $error("value_fifo: push while full, writer overspent credit");

    no_pop_when_empty: assert property (
        @(posedge clk) disable iff (rst)
        pop |-> !fifo_empty
    ) else $error("value_fifo: pop while empty");

endmodule

//--- design/update_ctrl.sv
module update_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic frame_start,
    input  logic fifo_empty,
    output logic pop,
    output logic load,
    output logic blank
);

    import seg_display_pkg::*;

    logic state;
    logic state_nxt;

    //////////////////////////////////////////////////////////////////////
    // Commit decision
    //////////////////////////////////////////////////////////////////////

    // Only a frame boundary may swap the shown value, so a frame never tears
    assign pop  = frame_start & ~fifo_empty;
    assign load = pop;

    always_comb begin
        state_nxt = state;
        case (state)
            st_blank: begin
                if (load) begin
                    state_nxt = st_show;
                end
            end
            // SHOW is sticky so the last value stays up while the queue is dry
            st_show: state_nxt = st_show;
            default: state_nxt = st_blank;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_blank;
        end else begin
            state <= state_nxt;
        end
    end

    assign blank = (state == st_blank);

    // Commit only on the frame boundary from scan_timer
    load_on_frame: assert property (
        @(posedge clk) disable iff (rst)
        load |-> frame_start
    ) else $error("update_ctrl: load outside a frame_start cycle");

endmodule

//--- design/display_seg.sv
module display_seg (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    load,
    input  logic [seg_display_pkg::value_width-1:0] load_data,
    input  logic                                    phase,
    input  logic                                    blank,
    output logic [seg_display_pkg::seg_width-1:0]   seg1,
    output logic [seg_display_pkg::seg_width-1:0]   seg2,
    output logic [seg_display_pkg::seg_width-1:0]   seg3,
    output logic [seg_display_pkg::seg_width-1:0]   seg4,
    output logic [seg_display_pkg::an_width-1:0]    ans
);

    import seg_display_pkg::*;

    localparam int n_dec = 4;

    logic [value_width-1:0]  shown;
    logic [nibble_width-1:0] digit [n_dec];
    logic [seg_width-1:0]    dec   [n_dec];

    //////////////////////////////////////////////////////////////////////
    // Shown value
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shown <= '0;
        end else if (load) begin
            shown <= load_data;
        end
    end

    // Decoder i serves byte i, high nibble in phase 0 and low in phase 1
    for (genvar i = 0; i < n_dec; i++) begin : g_dec
        assign digit[i] = phase ? shown[8*i +: nibble_width]
                                : shown[8*i + nibble_width +: nibble_width];

        seg7 u_seg7 (
            .din (digit[i]),
            .dout(dec[i])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // Outputs
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (blank) begin
            ans  = an_blank;
            seg1 = '0;
            seg2 = '0;
            seg3 = '0;
            seg4 = '0;
        end else begin
            ans  = phase ? an_phase_lo : an_phase_hi;
            seg1 = dec[0];
            seg2 = dec[1];
            seg3 = dec[2];
            seg4 = dec[3];
        end
    end

endmodule

//--- design/seg_display_top.sv
module seg_display_top #(
    parameter int div_factor = seg_display_pkg::default_div_factor
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    value_valid,
    input  logic [seg_display_pkg::value_width-1:0] value_data,
    output logic                                    credit_return,
    output logic [seg_display_pkg::seg_width-1:0]   seg1,
    output logic [seg_display_pkg::seg_width-1:0]   seg2,
    output logic [seg_display_pkg::seg_width-1:0]   seg3,
    output logic [seg_display_pkg::seg_width-1:0]   seg4,
    output logic [seg_display_pkg::an_width-1:0]    ans
);

    import seg_display_pkg::*;

    // Scan timing
    logic phase;
    logic frame_start;

    // Queue to controller and display
    logic                   fifo_empty;
    logic [value_width-1:0] head_data;
    logic                   pop;
    logic                   load;
    logic                   blank;

    //////////////////////////////////////////////////////////////////////
    // Refresh timing
    //////////////////////////////////////////////////////////////////////

    scan_timer #(
        .div_factor(div_factor)
    ) u_scan_timer (
        .clk        (clk),
        .rst        (rst),
        .phase      (phase),
        .frame_start(frame_start)
    );

    //////////////////////////////////////////////////////////////////////
    // Value queue and commit control
    //////////////////////////////////////////////////////////////////////

    value_fifo u_value_fifo (
        .clk          (clk),
        .rst          (rst),
        .push         (value_valid),
        .push_data    (value_data),
        .pop          (pop),
        .head_data    (head_data),
        .fifo_empty   (fifo_empty),
        .credit_return(credit_return)
    );

    update_ctrl u_update_ctrl (
        .clk        (clk),
        .rst        (rst),
        .frame_start(frame_start),
        .fifo_empty (fifo_empty),
        .pop        (pop),
        .load       (load),
        .blank      (blank)
    );

    // Digit multiplexing and decode
    display_seg u_display_seg (
        .clk      (clk),
        .rst      (rst),
        .load     (load),
        .load_data(head_data),
        .phase    (phase),
        .blank    (blank),
        .seg1     (seg1),
        .seg2     (seg2),
        .seg3     (seg3),
        .seg4     (seg4),
        .ans      (ans)
    );

endmodule

//--- verif/tb_seg_display.sv
module tb_seg_display;

    import seg_display_pkg::*;

    localparam int div_factor     = 4;
    localparam int clk_period     = 4;
    localparam int reset_cycles   = 10;
    localparam int num_pushes     = 40;
    localparam int frame_cycles   = 2 * div_factor;
    localparam int margin_cycles  = 1000;
    localparam int timeout_cycles = num_pushes * 2 * 2 * div_factor + reset_cycles
                                    + margin_cycles;

    logic                   clk;
    logic                   rst;
    logic                   value_valid;
    logic [value_width-1:0] value_data;
    logic                   credit_return;
    logic [seg_width-1:0]   seg1;
    logic [seg_width-1:0]   seg2;
    logic [seg_width-1:0]   seg3;
    logic [seg_width-1:0]   seg4;
    logic [an_width-1:0]    ans;

    // Reference model state
    logic [value_width-1:0] model_q [$];
    logic [value_width-1:0] m_shown;
    bit                     m_blank;
    bit                     m_phase;
    int                     m_cnt;
    bit                     m_credit_due;
    int                     commits;
    int                     late_pushes;

    // Writer state
    int credits;
    int pushes_sent;

    seg_display_top #(
        .div_factor(div_factor)
    ) UUT (
        .clk          (clk),
        .rst          (rst),
        .value_valid  (value_valid),
        .value_data   (value_data),
        .credit_return(credit_return),
        .seg1         (seg1),
        .seg2         (seg2),
        .seg3         (seg3),
        .seg4         (seg4),
        .ans          (ans)
    );

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    // Hex digit to segments with bit 6 as g and bit 0 as a
    function automatic logic [seg_width-1:0] hex_to_seg(input logic [nibble_width-1:0] n);
        case (n)
            4'h0:    return 7'h3f;
            4'h1:    return 7'h06;
            4'h2:    return 7'h5b;
            4'h3:    return 7'h4f;
            4'h4:    return 7'h66;
            4'h5:    return 7'h6d;
            4'h6:    return 7'h7d;
            4'h7:    return 7'h07;
            4'h8:    return 7'h7f;
            4'h9:    return 7'h6f;
            4'ha:    return 7'h77;
            4'hb:    return 7'h7c;
            4'hc:    return 7'h39;
            4'hd:    return 7'h5e;
            4'he:    return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    // Phase 0 shows the high nibble of each byte, phase 1 the low one
    function automatic logic [nibble_width-1:0] pick_nibble(input logic [value_width-1:0] v,
                                                            input int idx, input bit ph);
        return ph ? v[8*idx +: nibble_width] : v[8*idx + nibble_width +: nibble_width];
    endfunction

    function automatic logic [an_width-1:0] expected_ans(input bit blank, input bit ph);
        if (blank) begin
            return an_blank;
        end
        return ph ? an_phase_lo : an_phase_hi;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s expected 0x%0h, got 0x%0h at time %0t",
                     name, expected, actual, $time);
            $display("Result: FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic fail_run(input string reason);
        $display("Error: %s at time %0t", reason, $time);
        $display("Result: FAILED");
        $fatal(1, "run stopped");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Clock, watchdog and sequencing
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(timeout_cycles * clk_period);
        $display("Error: watchdog expired after %0d cycles before all values were shown",
                 timeout_cycles);
        $display("Result: FAILED");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        void'($urandom(27031));
        rst         = 1'b1;
        value_valid = 1'b0;
        value_data  = '0;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;

        // Done once every value is committed and every credit is back
        while (!(pushes_sent == num_pushes && model_q.size() == 0
                 && credits == credit_count)) begin
            @(negedge clk);
        end
        repeat (2 * frame_cycles) @(negedge clk);

        $display("Info: %0d values shown, %0d pushed in frame_start cycles",
                 commits, late_pushes);
        $display("Result: PASSED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Writer with credit counter
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin : writer
        bit burst;
        bit want;
        if (rst) begin
            credits     = credit_count;
            pushes_sent = 0;
            value_valid <= 1'b0;
        end else begin
            if (credit_return) begin
                credits++;
            end
            if (credits > credit_count) begin
                fail_run("more credits returned than were spent");
            end
            // Alternate bursts that drain the credit with sparse traffic
            burst = ((pushes_sent / 8) % 2) == 0;
            want  = burst ? (($urandom % 8) != 0) : (($urandom % 6) == 0);
            if (pushes_sent < num_pushes && credits > 0 && want) begin
                value_valid <= 1'b1;
                value_data  <= $urandom;
                credits--;
                pushes_sent++;
            end else begin
                value_valid <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model and output checks
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin : scoreboard
        logic [seg_width-1:0] got [4];
        logic [seg_width-1:0] exp_seg;
        int                   i;
        got[0] = seg1;
        got[1] = seg2;
        got[2] = seg3;
        got[3] = seg4;

        if (rst) begin
            model_q.delete();
            m_shown      = '0;
            m_blank      = 1'b1;
            m_phase      = 1'b0;
            m_cnt        = 0;
            m_credit_due = 1'b0;
            commits      = 0;
            late_pushes  = 0;
        end else begin
            check_value("ans", expected_ans(m_blank, m_phase), ans);
            for (i = 0; i < 4; i++) begin
                exp_seg = m_blank ? '0 : hex_to_seg(pick_nibble(m_shown, i, m_phase));
                check_value($sformatf("seg%0d", i + 1), exp_seg, got[i]);
            end
            check_value("credit_return", m_credit_due, credit_return);

            m_credit_due = 1'b0;
            // Last cycle of phase 1 where the next edge turns ans from lo to hi
            if (m_phase && m_cnt == div_factor - 1) begin
                if (model_q.size() > 0) begin
                    m_shown      = model_q.pop_front();
                    m_blank      = 1'b0;
                    m_credit_due = 1'b1;
                    commits++;
                end
                if (value_valid) begin
                    late_pushes++;
                end
            end
            // Push lands after the pop, so it waits for the next frame
            if (value_valid) begin
                model_q.push_back(value_data);
                if (model_q.size() > credit_count) begin
                    fail_run("queue holds more values than the credit allows");
                end
            end
            if (m_cnt == div_factor - 1) begin
                m_cnt   = 0;
                m_phase = ~m_phase;
            end else begin
                m_cnt++;
            end
        end
    end

endmodule

//--- seg_display.f
design/seg_display_pkg.sv
design/seg7.sv
design/scan_timer.sv
design/value_fifo.sv
design/update_ctrl.sv
design/display_seg.sv
design/seg_display_top.sv
verif/tb_seg_display.sv

//--- Bender.yml
package:
  name: seg_display

sources:
  - design/seg_display_pkg.sv
  - design/seg7.sv
  - design/scan_timer.sv
  - design/value_fifo.sv
  - design/update_ctrl.sv
  - design/display_seg.sv
  - design/seg_display_top.sv
  - target: simulation
    files:
      - verif/tb_seg_display.sv
